// ==== fdc_patterns.txt ====
# test op arg expect, arg and expect in hex
# write addr data | cmd/run/wsec/rsec cmd_byte | read addr value | status mask value | irq - level | idle cycles
restore run 00 0
restore status 15 04
restore read 1 00
seek write 3 05
seek run 10 0
seek status 15 00
seek read 1 05
step_in run 50 0
step_in read 1 06
write_read write 2 01
write_read wsec a0 0
write_read status 15 00
write_read rsec 80 0
write_read status 15 00
missing_sector write 2 04
missing_sector run 80 0
missing_sector status 11 10
lost_data write 2 02
lost_data run 80 0
lost_data status 15 04
force_int write 3 00
force_int cmd 13 0
force_int idle 14 0
force_int status 01 01
force_int cmd d8 0
force_int irq 0 1
force_int status 01 00

// ==== all.f ====
fdc_pkg.sv
fdc_regs.sv
fdc_step.sv
fdc_xfer.sv
disk_drive.sv
fdc_top.sv
fdc_assert.sv
tb_fdc.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = tb_fdc
FILELIST  = all.f
BUILD     = obj_dir
LOG       = sim.log
FAIL_MSG  = Checks failed
PASS_MSG  = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb_fdc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fdc import fdc_pkg::*; ();

   localparam int SECTOR_BYTES = 16;
   localparam int SECTORS      = 4;
   localparam int TIMEOUT      = 5000;   // Cycles, covers two revolutions

   logic       clk;
   logic       reset;
   cpu_bus_t   bus;
   logic [7:0] dout;
   logic       irq;
   logic       drq;

   logic [31:0] lcg_state;
   logic [7:0]  sector_buf [SECTOR_BYTES];
   string       test_name;
   int          test_errors;
   int          total_errors;
   int          checks;
   int          tests_run;
   int          tests_failed;

   fdc_top #(
      .SECTOR_BYTES(SECTOR_BYTES),
      .SECTORS(SECTORS),
      .BYTE_CYCLES(8),
      .STEP_UNIT(16),
      .TRACKS(8)
   ) UUT (
      .clk, .reset, .bus, .dout, .irq, .drq
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic cpu_write(input logic [1:0] a, input logic [7:0] v);
      @(posedge clk);
      bus <= '{cs: 1'b1, re: 1'b0, we: 1'b1, a: a, din: v};
      @(posedge clk);
      bus <= '0;
   endtask

   // dout is registered, so it is taken one cycle after the access
   task automatic cpu_read(input logic [1:0] a, output logic [7:0] v);
      @(posedge clk);
      bus <= '{cs: 1'b1, re: 1'b1, we: 1'b0, a: a, din: 8'h00};
      @(posedge clk);
      bus <= '0;
      @(negedge clk);
      v = dout;
   endtask

   task automatic wait_for(input string what, input logic level, output logic ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < TIMEOUT && !ok; n++) begin
         @(negedge clk);
         if (((what == "irq") ? irq : drq) == level)
            ok = 1'b1;
      end
      if (!ok) begin
         $display("%s: %s did not go to %0d within %0d cycles", test_name, what, level, TIMEOUT);
         test_errors++;
      end
   endtask

   task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
      checks++;
      if (act !== exp) begin
         $display("error %s: %s expected %02h actual %02h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic write_sector(input logic [7:0] cmd_byte);
      logic ok;
      int i;
      ok = 1'b1;
      cpu_write(ADDR_CMD, cmd_byte);
      for (i = 0; i < SECTOR_BYTES && ok; i++) begin
         wait_for("drq", 1'b1, ok);
         if (ok) begin
            lcg_state = lcg_next(lcg_state);
            sector_buf[i] = lcg_state[23:16];
            cpu_write(ADDR_DATA, sector_buf[i]);
            wait_for("drq", 1'b0, ok);   // Request taken back
         end
      end
      if (ok)
         wait_for("irq", 1'b1, ok);
   endtask

   task automatic read_sector(input logic [7:0] cmd_byte);
      logic       ok;
      logic [7:0] v;
      int         i;
      ok = 1'b1;
      cpu_write(ADDR_CMD, cmd_byte);
      for (i = 0; i < SECTOR_BYTES && ok; i++) begin
         wait_for("drq", 1'b1, ok);
         if (ok) begin
            cpu_read(ADDR_DATA, v);
            check_value($sformatf("byte %0d", i), sector_buf[i], v);
            wait_for("drq", 1'b0, ok);
         end
      end
      if (ok)
         wait_for("irq", 1'b1, ok);
   endtask

   task automatic run_op(input string op, input logic [7:0] arg, input logic [7:0] expv);
      logic [7:0] v;
      logic       ok;
      case (op)
         "write": cpu_write(arg[1:0], expv);
         "cmd":   cpu_write(ADDR_CMD, arg);
         "run": begin
            cpu_write(ADDR_CMD, arg);
            wait_for("irq", 1'b1, ok);
         end
         "read": begin
            cpu_read(arg[1:0], v);
            check_value($sformatf("register %0d", arg[1:0]), expv, v);
         end
         "status": begin
            cpu_read(ADDR_CMD, v);
            check_value("status", expv, v & arg);   // arg is the bit mask
         end
         "wsec": write_sector(arg);
         "rsec": read_sector(arg);
         "irq": begin
            @(negedge clk);
            check_value("irq", expv, {7'd0, irq});
         end
         "idle": repeat (arg) @(posedge clk);
         default: begin
            $display("%s: unknown operation %s in the pattern file", test_name, op);
            test_errors++;
         end
      endcase
   endtask

   task automatic finish_test();
      if (test_name != "") begin
         tests_run++;
         if (test_errors == 0) begin
            $display("test %s: ok", test_name);
         end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
         end
         total_errors += test_errors;
      end
      test_errors = 0;
   endtask

   initial begin
      int         fd;
      int         n;
      string      line;
      string      name;
      string      op;
      logic [7:0] arg;
      logic [7:0] expv;
      reset = 1'b1;
      bus = '0;
      lcg_state = 32'hd83f3c68;
      test_name = "";
      test_errors = 0;
      total_errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      fd = $fopen("fdc_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open fdc_patterns.txt");
         total_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#")
               continue;
            n = $sscanf(line, "%s %s %h %h", name, op, arg, expv);
            if (n != 4)
               continue;                     // Blank line
            if (name != test_name) begin
               finish_test();
               test_name = name;
            end
            run_op(op, arg, expv);
         end
         $fclose(fd);
         finish_test();
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, total_errors);
      if (total_errors == 0 && tests_run > 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== fdc_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_assert (
   input logic clk,
   input logic reset,
   input logic busy,
   input logic drq,
   input logic irq,
   input logic step
);

   // Data requests only come from a running command
   drq_in_command: assert property (@(posedge clk) disable iff (reset) drq |-> busy)
      else $error("drq high while the controller is not busy");

   // From reset on, the head only moves under a command
   step_in_command: assert property (@(posedge clk) disable iff (reset) step |-> busy)
      else $error("step pulse while the controller is not busy");

   irq_after_busy: assert property (@(posedge clk) disable iff (reset)
      $rose(irq) |-> $past(busy))
      else $error("irq raised without a command in progress");

endmodule

bind fdc_top fdc_assert u_assert (
   .clk, .reset, .busy(u_regs.busy), .drq, .irq, .step
);

`default_nettype wire

// ==== fdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_top import fdc_pkg::*; #(
   parameter int SECTOR_BYTES = 16,
   parameter int SECTORS      = 4,
   parameter int BYTE_CYCLES  = 8,
   parameter int STEP_UNIT    = 16,
   parameter int TRACKS       = 8
) (
   input  logic       clk,
   input  logic       reset,
   input  cpu_bus_t   bus,
   output logic [7:0] dout,
   output logic       irq,
   output logic       drq
);

   cmd_t         cmd;
   xfer_status_t xstat;
   drive_t       drive;
   disk_wr_t     disk_wr;
   logic         start, abort, data_access;
   logic         track_load, step_done, rnf_step, step, dirc;
   logic [7:0]   track, sector, data, track_next, rd_byte, head_track;

   assign drq = xstat.drq;

   fdc_regs u_regs (
      .clk, .reset, .bus, .dout, .cmd, .start, .abort,
      .track, .sector, .data, .track_next, .track_load, .step_done, .rnf_step,
      .xstat, .rd_byte, .tr00(drive.tr00), .index(drive.index), .data_access, .irq
   );

   fdc_step #(.STEP_UNIT(STEP_UNIT)) u_step (
      .clk, .reset, .start, .abort, .cmd, .track, .data, .tr00(drive.tr00),
      .track_next, .track_load, .step, .dirc, .step_done, .rnf_step
   );

   fdc_xfer #(.SECTOR_BYTES(SECTOR_BYTES), .SECTORS(SECTORS)) u_xfer (
      .clk, .reset, .start, .abort, .cmd, .track, .sector, .data,
      .drive, .head_track, .data_access, .xstat, .rd_byte, .disk_wr
   );

   disk_drive #(
      .SECTOR_BYTES(SECTOR_BYTES),
      .SECTORS(SECTORS),
      .BYTE_CYCLES(BYTE_CYCLES),
      .TRACKS(TRACKS)
   ) u_drive (
      .clk, .reset, .step, .dirc, .disk_wr, .drive, .head_track
   );

endmodule

`default_nettype wire

// ==== disk_drive.sv ====
`timescale 1ns/1ps
`default_nettype none

module disk_drive import fdc_pkg::*; #(
   parameter int SECTOR_BYTES = 16,
   parameter int SECTORS      = 4,
   parameter int BYTE_CYCLES  = 8,
   parameter int TRACKS       = 8
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       step,
   input  logic       dirc,
   input  disk_wr_t   disk_wr,
   output drive_t     drive,
   output logic [7:0] head_track
);

   localparam int DEPTH = TRACKS * SECTORS * SECTOR_BYTES;
   localparam int AW    = $clog2(DEPTH);
   localparam int CW    = $clog2(BYTE_CYCLES + 1);

   logic [7:0]    mem [DEPTH];
   logic [CW-1:0] cyc;
   logic [7:0]    bpos, rd_q;
   logic [2:0]    sid, sid_q;
   logic          step_q, tick_q, index_q, tr00_q;
   logic [AW-1:0] rd_addr, wr_addr;

   assign rd_addr = AW'((head_track * SECTORS + sid_q) * SECTOR_BYTES + disk_wr.pos);
   assign wr_addr = AW'((head_track * SECTORS + disk_wr.sector) * SECTOR_BYTES + disk_wr.pos);

   assign drive = '{index: index_q, byte_tick: tick_q, tr00: tr00_q,
                    sector_id: sid_q, rd_data: rd_q};

   always_ff @(posedge clk) begin
      if (reset) begin
         cyc <= '0;
         bpos <= 8'd0;
         sid <= 3'd0;
         sid_q <= 3'd0;
         step_q <= 1'b0;
         tick_q <= 1'b0;
         index_q <= 1'b0;
         tr00_q <= 1'b0;
         head_track <= 8'(TRACKS - 1);   // Head parked at the far end
      end else begin
         step_q <= step;
         tr00_q <= head_track == 8'd0;
         tick_q <= 1'b0;
         index_q <= 1'b0;
         if (step && !step_q) begin
            if (dirc && head_track != 8'd0)
               head_track <= head_track - 8'd1;
            else if (!dirc && head_track != 8'(TRACKS - 1))
               head_track <= head_track + 8'd1;
         end
         if (cyc == CW'(BYTE_CYCLES - 1)) begin
            cyc <= '0;
            tick_q <= 1'b1;
            index_q <= bpos == 8'd0 && sid == 3'd0;
            sid_q <= sid;                     // Sector of the byte now passing
            if (bpos == 8'(SECTOR_BYTES - 1)) begin
               bpos <= 8'd0;
               sid <= (sid == 3'(SECTORS - 1)) ? 3'd0 : sid + 3'd1;
            end else begin
               bpos <= bpos + 8'd1;
            end
         end else begin
            cyc <= cyc + CW'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tick_q)
         rd_q <= mem[rd_addr];
      if (disk_wr.wr)
         mem[wr_addr] <= disk_wr.data;
   end

endmodule

`default_nettype wire

// ==== fdc_xfer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_xfer import fdc_pkg::*; #(
   parameter int SECTOR_BYTES = 16,
   parameter int SECTORS      = 4
) (
   input  logic         clk,
   input  logic         reset,
   input  logic         start,
   input  logic         abort,
   input  cmd_t         cmd,
   input  logic [7:0]   track,
   input  logic [7:0]   sector,
   input  logic [7:0]   data,
   input  drive_t       drive,
   input  logic [7:0]   head_track,
   input  logic         data_access,
   output xfer_status_t xstat,
   output logic [7:0]   rd_byte,
   output disk_wr_t     disk_wr
);

   typedef enum logic [1:0] {X_IDLE, X_SEARCH, X_DATA, X_TAIL} state_e;

   state_e     state;
   logic       writing, seen_index, tick_q;
   logic [2:0] last_sid;
   logic       match, sector_start, last_byte, late;

   // Sector numbers past the track never alias onto the 3-bit id
   assign match = head_track == track && sector < 8'(SECTORS)
                  && sector[2:0] == drive.sector_id;
   assign sector_start = drive.byte_tick && (drive.index || drive.sector_id != last_sid);
   assign last_byte = disk_wr.pos == 8'(SECTOR_BYTES - 1);
   assign late = xstat.drq && !data_access;   // Previous byte not served

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= X_IDLE;
         xstat <= '0;
         disk_wr.wr <= 1'b0;
         disk_wr.pos <= 8'd0;
         writing <= 1'b0;
         seen_index <= 1'b0;
         tick_q <= 1'b0;
         last_sid <= 3'd0;
      end else begin
         xstat.byte_valid <= 1'b0;
         xstat.done <= 1'b0;
         disk_wr.wr <= 1'b0;
         tick_q <= drive.byte_tick;
         if (drive.byte_tick)
            last_sid <= drive.sector_id;
         if (data_access)
            xstat.drq <= 1'b0;
         if (disk_wr.wr)
            disk_wr.pos <= disk_wr.pos + 8'd1;   // Advance after the RAM write
         if (abort) begin
            state <= X_IDLE;
            xstat.drq <= 1'b0;
         end else begin
            case (state)
               X_IDLE: begin
                  if (start && (cmd.kind == CMD_READ || cmd.kind == CMD_WRITE)) begin
                     writing <= cmd.kind == CMD_WRITE;
                     seen_index <= 1'b0;
                     xstat.drq <= 1'b0;
                     xstat.lost_data <= 1'b0;
                     xstat.rnf <= 1'b0;
                     disk_wr.pos <= 8'd0;
                     disk_wr.sector <= sector[2:0];
                     state <= X_SEARCH;
                  end
               end
               X_SEARCH: begin
                  if (sector_start && match) begin
                     if (writing)
                        xstat.drq <= 1'b1;    // Ask for byte 0 right away
                     state <= X_DATA;
                  end else if (drive.index) begin
                     if (seen_index) begin
                        xstat.rnf <= 1'b1;
                        xstat.done <= 1'b1;
                        state <= X_IDLE;
                     end
                     seen_index <= 1'b1;
                  end
               end
               X_DATA: begin
                  if (writing) begin
                     if (drive.byte_tick) begin
                        if (late)
                           xstat.lost_data <= 1'b1;
                        disk_wr.wr <= 1'b1;
                        disk_wr.data <= data;
                        xstat.drq <= !last_byte;
                        if (last_byte) begin
                           xstat.done <= 1'b1;
                           state <= X_IDLE;
                        end
                     end
                  end else if (tick_q) begin   // RAM output is valid now
                     if (late)
                        xstat.lost_data <= 1'b1;
                     rd_byte <= drive.rd_data;
                     xstat.byte_valid <= 1'b1;
                     xstat.drq <= 1'b1;
                     if (last_byte)
                        state <= X_TAIL;
                     else
                        disk_wr.pos <= disk_wr.pos + 8'd1;
                  end
               end
               default: begin
                  // Last read byte gets one byte time to be taken
                  if (drive.byte_tick) begin
                     if (late)
                        xstat.lost_data <= 1'b1;
                     xstat.drq <= 1'b0;
                     xstat.done <= 1'b1;
                     state <= X_IDLE;
                  end
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== fdc_step.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_step import fdc_pkg::*; #(
   parameter int STEP_UNIT = 16
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       start,
   input  logic       abort,
   input  cmd_t       cmd,
   input  logic [7:0] track,
   input  logic [7:0] data,
   input  logic       tr00,
   output logic [7:0] track_next,
   output logic       track_load,
   output logic       step,
   output logic       dirc,
   output logic       step_done,
   output logic       rnf_step
);

   localparam int DW = $clog2(4 * STEP_UNIT);

   typedef enum logic [2:0] {
      S_IDLE, S_COMPARE, S_STEP, S_PULSE, S_SETTLE, S_FINISH
   } state_e;

   state_e        state;
   logic [DW-1:0] delay, period;
   logic [7:0]    steps;

   // Rate codes 0..3 give 1, 1, 2, 4 units; the counter runs period+1 cycles
   always_comb begin
      case (cmd.flags[1:0])
         2'd2:    period = DW'(2 * STEP_UNIT - 1);
         2'd3:    period = DW'(4 * STEP_UNIT - 1);
         default: period = DW'(STEP_UNIT - 1);
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_IDLE;
         delay <= '0;
         steps <= 8'd0;
         step <= 1'b0;
         dirc <= 1'b0;
         track_load <= 1'b0;
         step_done <= 1'b0;
         rnf_step <= 1'b0;
      end else begin
         track_load <= 1'b0;
         step_done <= 1'b0;
         rnf_step <= 1'b0;
         if (abort) begin
            state <= S_IDLE;
            step <= 1'b0;
         end else begin
            case (state)
               S_IDLE: begin
                  if (start && cmd.kind inside {CMD_RESTORE, CMD_SEEK, CMD_STEP}) begin
                     steps <= 8'd0;
                     if (cmd.kind == CMD_STEP) begin
                        if (cmd.set_dir)
                           dirc <= cmd.dir;
                        state <= S_STEP;
                     end else begin
                        state <= S_COMPARE;
                     end
                  end
               end
               S_COMPARE: begin
                  if (cmd.kind == CMD_RESTORE) begin
                     if (tr00) begin
                        track_next <= 8'd0;
                        track_load <= 1'b1;
                        state <= S_FINISH;
                     end else if (steps == 8'd255) begin
                        rnf_step <= 1'b1;         // Track zero never seen
                        state <= S_FINISH;
                     end else begin
                        dirc <= 1'b1;
                        state <= S_STEP;
                     end
                  end else if (data == track) begin
                     state <= S_FINISH;
                  end else begin
                     dirc <= data < track;
                     state <= S_STEP;
                  end
               end
               S_STEP: begin
                  step <= 1'b1;
                  steps <= steps + 8'd1;
                  delay <= period;
                  if (cmd.upd) begin
                     track_next <= dirc ? track - 8'd1 : track + 8'd1;
                     track_load <= 1'b1;
                  end
                  state <= S_PULSE;
               end
               S_PULSE: begin
                  if (delay == '0) begin
                     step <= 1'b0;
                     // Compare and step states take up the last two gap cycles
                     delay <= (period > DW'(1)) ? period - DW'(2) : '0;
                     state <= S_SETTLE;
                  end else begin
                     delay <= delay - DW'(1);
                  end
               end
               S_SETTLE: begin
                  if (delay == '0)
                     state <= (cmd.kind == CMD_STEP) ? S_FINISH : S_COMPARE;
                  else
                     delay <= delay - DW'(1);
               end
               default: begin
                  step_done <= 1'b1;
                  state <= S_IDLE;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== fdc_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_regs import fdc_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  cpu_bus_t     bus,
   output logic [7:0]   dout,
   output cmd_t         cmd,
   output logic         start,
   output logic         abort,
   output logic [7:0]   track,
   output logic [7:0]   sector,
   output logic [7:0]   data,
   input  logic [7:0]   track_next,
   input  logic         track_load,
   input  logic         step_done,
   input  logic         rnf_step,
   input  xfer_status_t xstat,
   input  logic [7:0]   rd_byte,
   input  logic         tr00,
   input  logic         index,
   output logic         data_access,
   output logic         irq
);

   cmd_t       cmd_dec;
   logic       wr_en, rd_en, type1;
   logic       busy, rnf_q, int_index;
   logic [7:0] status;

   assign wr_en = bus.cs & bus.we;
   assign rd_en = bus.cs & bus.re;
   assign type1 = cmd.kind inside {CMD_RESTORE, CMD_SEEK, CMD_STEP};

   // Force interrupt stops both engines in the cycle of the write
   assign abort = wr_en && bus.a == ADDR_CMD && cmd_dec.kind == CMD_FORCE_INT;

   always_comb begin
      cmd_dec = '0;
      cmd_dec.flags = bus.din[3:0];
      casez (bus.din[7:4])
         4'b0000: cmd_dec.kind = CMD_RESTORE;
         4'b0001: begin
            cmd_dec.kind = CMD_SEEK;
            cmd_dec.upd = 1'b1;
         end
         4'b001?: begin
            cmd_dec.kind = CMD_STEP;
            cmd_dec.upd = bus.din[4];
         end
         4'b01??: begin             // Step-in / step-out
            cmd_dec.kind = CMD_STEP;
            cmd_dec.upd = bus.din[4];
            cmd_dec.set_dir = 1'b1;
            cmd_dec.dir = bus.din[5];
         end
         4'b100?: cmd_dec.kind = CMD_READ;
         4'b101?: cmd_dec.kind = CMD_WRITE;
         4'b1101: cmd_dec.kind = CMD_FORCE_INT;
         default: cmd_dec.kind = CMD_UNSUPPORTED;
      endcase
   end

   always_comb begin
      status = 8'h00;
      status[0] = busy;
      status[1] = type1 ? index : xstat.drq;
      status[2] = type1 ? tr00 : xstat.lost_data;
      status[4] = rnf_q | xstat.rnf;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd <= '0;
         start <= 1'b0;
         track <= 8'h00;
         sector <= 8'h00;
         data_access <= 1'b0;
         irq <= 1'b0;
         busy <= 1'b0;
         rnf_q <= 1'b0;
         int_index <= 1'b0;
      end else begin
         start <= 1'b0;
         data_access <= (wr_en | rd_en) && bus.a == ADDR_DATA;
         if (track_load)
            track <= track_next;
         if (xstat.byte_valid)
            data <= rd_byte;
         if (rnf_step)
            rnf_q <= 1'b1;
         if (rd_en && bus.a == ADDR_CMD)
            irq <= 1'b0;                  // Status read acknowledges
         if (step_done || xstat.done || (start && cmd.kind == CMD_UNSUPPORTED)) begin
            busy <= 1'b0;
            irq <= 1'b1;
         end
         if (int_index && index)
            irq <= 1'b1;
         if (wr_en) begin
            case (bus.a)
               ADDR_CMD: begin
                  if (cmd_dec.kind == CMD_FORCE_INT) begin
                     cmd <= cmd_dec;
                     busy <= 1'b0;
                     irq <= cmd_dec.flags[3];
                     int_index <= cmd_dec.flags[2];
                  end else if (!busy) begin  // Commands are ignored while busy
                     cmd <= cmd_dec;
                     start <= 1'b1;
                     busy <= 1'b1;
                     irq <= 1'b0;
                     rnf_q <= 1'b0;
                     int_index <= 1'b0;
                  end
               end
               ADDR_TRACK:  track <= bus.din;
               ADDR_SECTOR: sector <= bus.din;
               default:     data <= bus.din;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         case (bus.a)
            ADDR_CMD:    dout <= status;
            ADDR_TRACK:  dout <= track;
            ADDR_SECTOR: dout <= sector;
            default:     dout <= data;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== fdc_pkg.sv ====
`default_nettype none

package fdc_pkg;

   typedef enum logic [2:0] {
      CMD_RESTORE,
      CMD_SEEK,
      CMD_STEP,
      CMD_READ,
      CMD_WRITE,
      CMD_FORCE_INT,
      CMD_UNSUPPORTED
   } cmd_kind_e;

   // One CPU access
   typedef struct packed {
      logic       cs;
      logic       re;
      logic       we;
      logic [1:0] a;
      logic [7:0] din;
   } cpu_bus_t;

   typedef struct packed {
      cmd_kind_e  kind;
      logic [3:0] flags;   // Type I: h v r1 r0, Type IV: interrupt conditions
      logic       dir;     // 1 steps out toward track 0
      logic       upd;     // Track register follows the head
      logic       set_dir; // Step-in/out, plain step keeps the last direction
      logic [1:0] spare;
   } cmd_t;

   typedef struct packed {
      logic drq;
      logic lost_data;
      logic rnf;
      logic byte_valid;
      logic done;
   } xfer_status_t;

   typedef struct packed {
      logic       index;
      logic       byte_tick;
      logic       tr00;
      logic [2:0] sector_id;
      logic [7:0] rd_data;
   } drive_t;

   typedef struct packed {
      logic       wr;
      logic [2:0] sector;
      logic [7:0] pos;
      logic [7:0] data;
   } disk_wr_t;

   localparam logic [1:0] ADDR_CMD    = 2'd0;
   localparam logic [1:0] ADDR_TRACK  = 2'd1;
   localparam logic [1:0] ADDR_SECTOR = 2'd2;
   localparam logic [1:0] ADDR_DATA   = 2'd3;

endpackage

`default_nettype wire
